// ==== Makefile ====
SIM      = verilator
FLAGS    = --binary --timing --assert --timescale 1ns/1ps -j 0
TOP      = tb_ce_top
FILELIST = src.f
OBJ_DIR  = obj_dir

.PHONY: all compile run clean

all: run

compile:
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)

// ==== bench/ce_stim.txt ====
// Header: data pattern, number of jobs; a host word is its byte address XOR the pattern
// Jobs: host_addr hps_addr size_words bad_cpl_beat bad_write exp_status
// ffff means no error injected; status 2 is done, 4 is error
0123456789abcdef 7
00001000 20000000 0010 ffff ffff 2
00002000 20001000 0023 ffff ffff 2
00003000 20002000 0018 0009 ffff 4
00004000 20003000 0014 ffff ffff 2
00005000 20004000 0010 ffff 0006 4
00006100 20005000 0040 ffff ffff 2
00000040 30000000 0001 ffff ffff 2

// ==== bench/tb_ce_top.sv ====
module tb_ce_top;

   timeunit 1ns;
   timeprecision 1ps;

   localparam int STIM_WORDS = 64;
   localparam int JOB_FIELDS = 6;

   logic                             clk = 1'b0;
   logic                             rst;
   logic                             csr_wen;
   logic                             csr_ren;
   logic [ce_pkg::CE_CSR_ADDR_W-1:0] csr_addr;
   logic [63:0]                      csr_wdata;
   logic [63:0]                      csr_rdata;
   logic                             csr_rvalid;
   logic                             rd_req_valid;
   logic [31:0]                      rd_req_addr;
   logic                             rd_req_ready = 1'b0;
   logic                             cpl_valid = 1'b0;
   logic [63:0]                      cpl_data = '0;
   logic                             cpl_err = 1'b0;
   logic                             hps_wr_valid;
   logic [31:0]                      hps_wr_addr;
   logic [63:0]                      hps_wr_data;
   logic                             hps_wr_ready = 1'b0;
   logic                             hps_bvalid = 1'b0;
   logic                             hps_berr = 1'b0;
   logic                             ce_done;

   // Job setup taken from the stimulus file
   logic [63:0] stim_mem [0:STIM_WORDS-1];
   logic [63:0] pattern;
   logic [31:0] job_host;
   logic [31:0] job_hps;
   logic [15:0] job_size;
   logic [15:0] bad_beat;
   logic [15:0] bad_write;
   logic        new_job = 1'b0;

   // Memory model state
   logic [15:0] lfsr_q = 16'd75;
   logic [31:0] beat_q [$];
   logic        resp_q [$];
   int          req_idx = 0;
   int          beat_idx = 0;
   int          wr_idx = 0;
   int          cycle_cnt = 0;
   int          cycle_limit = 1000;

   ce_top i_dut (.*);

   always #50 clk = ~clk;

   // ------------------------------
   // Helpers
   // ------------------------------
   task automatic check_eq(input string what, input logic [63:0] got, input logic [63:0] exp);
      if (got !== exp) begin
         $display("Error at %0t ns: %s is %h, expected %h", $time, what, got, exp);
         $display("CHECKS FAILED");
         $fatal(1, "value mismatch");
      end
   endtask

   // 16-bit Fibonacci LFSR, taps 16 14 13 11
   function automatic logic [15:0] lfsr_next(input logic [15:0] s);
      return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
   endfunction

   task automatic draw_bit(output logic b);
      lfsr_q = lfsr_next(lfsr_q);
      b = lfsr_q[0];
   endtask

   task automatic write_reg(input logic [2:0] addr, input logic [63:0] data);
      @(posedge clk);
      csr_wen   <= 1'b1;
      csr_addr  <= addr;
      csr_wdata <= data;
      @(posedge clk);
      csr_wen   <= 1'b0;
   endtask

   task automatic read_reg(input logic [2:0] addr, output logic [63:0] data);
      @(posedge clk);
      csr_ren  <= 1'b1;
      csr_addr <= addr;
      @(posedge clk);
      csr_ren  <= 1'b0;
      @(posedge clk);
      check_eq("csr_rvalid", 64'(csr_rvalid), 64'd1);
      data = csr_rdata;
   endtask

   task automatic verify_reg(input logic [2:0] addr, input logic [63:0] exp, input string what);
      logic [63:0] rd;
      read_reg(addr, rd);
      check_eq(what, rd, exp);
   endtask

   // Wait until no request, beat, write or response is left in flight
   task automatic drain_models();
      do @(posedge clk);
      while (beat_q.size() != 0 || resp_q.size() != 0 || rd_req_valid ||
             hps_wr_valid || cpl_valid || hps_bvalid);
      repeat (4) @(posedge clk);
   endtask

   // ------------------------------
   // Host and HPS memory models
   // ------------------------------
   always @(posedge clk) begin
      logic        bit_r;
      logic [31:0] a;
      if (new_job) begin
         req_idx  = 0;
         beat_idx = 0;
         wr_idx   = 0;
      end
      if (rd_req_valid && rd_req_ready) begin
         a = job_host + 32'(req_idx * ce_pkg::CE_CHUNK_BYTES);
         check_eq("read request address", 64'(rd_req_addr), 64'(a));
         for (int i = 0; i < ce_pkg::CE_CHUNK_BEATS; i++) begin
            beat_q.push_back(a + 32'(i * ce_pkg::CE_BEAT_BYTES));
         end
         req_idx++;
      end
      draw_bit(bit_r);
      rd_req_ready <= bit_r;
      // Completion beats in request order, with random gaps
      draw_bit(bit_r);
      if (beat_q.size() != 0 && bit_r) begin
         a = beat_q.pop_front();
         cpl_valid <= 1'b1;
         cpl_data  <= 64'(a) ^ pattern;
         cpl_err   <= (16'(beat_idx) == bad_beat);
         beat_idx++;
      end else begin
         cpl_valid <= 1'b0;
         cpl_err   <= 1'b0;
      end
      if (hps_wr_valid && hps_wr_ready) begin
         a = 32'(wr_idx * ce_pkg::CE_BEAT_BYTES);
         check_eq("HPS write address", 64'(hps_wr_addr), 64'(job_hps + a));
         check_eq("HPS write data", hps_wr_data, 64'(job_host + a) ^ pattern);
         resp_q.push_back(16'(wr_idx) == bad_write);
         wr_idx++;
      end
      draw_bit(bit_r);
      hps_wr_ready <= bit_r;
      // Responses come back after a random delay
      draw_bit(bit_r);
      if (resp_q.size() != 0 && bit_r) begin
         hps_bvalid <= 1'b1;
         hps_berr   <= resp_q.pop_front();
      end else begin
         hps_bvalid <= 1'b0;
         hps_berr   <= 1'b0;
      end
   end

   always @(posedge clk) begin
      cycle_cnt <= cycle_cnt + 1;
      if (cycle_cnt >= cycle_limit) begin
         $display("Timeout after %0d cycles, the transfer never finished", cycle_cnt);
         $display("CHECKS FAILED");
         $fatal(1, "timeout");
      end
   end

   // ------------------------------
   // One transfer job
   // ------------------------------
   task automatic run_job(input int j);
      int          base;
      logic [63:0] exp_status;
      logic [63:0] rd;
      base       = 2 + j * JOB_FIELDS;
      job_host   = stim_mem[base][31:0];
      job_hps    = stim_mem[base + 1][31:0];
      job_size   = stim_mem[base + 2][15:0];
      bad_beat   = stim_mem[base + 3][15:0];
      bad_write  = stim_mem[base + 4][15:0];
      exp_status = stim_mem[base + 5];
      write_reg(ce_pkg::CE_REG_HOST_ADDR, 64'(job_host));
      write_reg(ce_pkg::CE_REG_HPS_ADDR, 64'(job_hps));
      write_reg(ce_pkg::CE_REG_SIZE, 64'(job_size));
      verify_reg(ce_pkg::CE_REG_HOST_ADDR, 64'(job_host), "host address readback");
      verify_reg(ce_pkg::CE_REG_HPS_ADDR, 64'(job_hps), "HPS address readback");
      verify_reg(ce_pkg::CE_REG_SIZE, 64'(job_size), "size readback");
      @(posedge clk);
      new_job <= 1'b1;
      @(posedge clk);
      new_job <= 1'b0;
      write_reg(ce_pkg::CE_REG_CTRL, 64'd1 << ce_pkg::CE_CTRL_START_BIT);
      verify_reg(ce_pkg::CE_REG_STATUS, 64'd1 << ce_pkg::CE_STAT_BUSY_BIT, "status after start");
      if (exp_status[ce_pkg::CE_STAT_ERR_BIT]) begin
         rd = '0;
         while (!rd[ce_pkg::CE_STAT_ERR_BIT]) read_reg(ce_pkg::CE_REG_STATUS, rd);
         check_eq("ce_done after error", 64'(ce_done), 64'd0);
      end else begin
         while (!ce_done) @(posedge clk);
      end
      drain_models();
      verify_reg(ce_pkg::CE_REG_STATUS, exp_status, "final status");
      check_eq("ce_done at job end", 64'(ce_done), 64'(exp_status[ce_pkg::CE_STAT_DONE_BIT]));
      if (exp_status[ce_pkg::CE_STAT_ERR_BIT]) begin
         write_reg(ce_pkg::CE_REG_CTRL, 64'd1 << ce_pkg::CE_CTRL_SOFTRST_BIT);
         verify_reg(ce_pkg::CE_REG_STATUS, 64'd0, "status after soft reset");
      end else begin
         check_eq("write count", 64'(wr_idx), 64'(job_size));
         check_eq("request count", 64'(req_idx), 64'((int'(job_size) + 3) / 4));
      end
   endtask

   initial begin
      int num_jobs;
      int total_words;
      rst       = 1'b1;
      csr_wen   = 1'b0;
      csr_ren   = 1'b0;
      csr_addr  = '0;
      csr_wdata = '0;
      job_host  = '0;
      job_hps   = '0;
      job_size  = '0;
      bad_beat  = 16'hffff;
      bad_write = 16'hffff;
      $readmemh("bench/ce_stim.txt", stim_mem);
      if ($isunknown(stim_mem[1]) || 2 + int'(stim_mem[1]) * JOB_FIELDS > STIM_WORDS) begin
         $display("The stimulus file bench/ce_stim.txt is missing or malformed");
         $display("CHECKS FAILED");
         $fatal(1, "no stimulus");
      end
      pattern     = stim_mem[0];
      num_jobs    = int'(stim_mem[1]);
      total_words = 0;
      for (int j = 0; j < num_jobs; j++) begin
         total_words += int'(stim_mem[2 + j * JOB_FIELDS + 2][15:0]);
      end
      cycle_limit = 200 * total_words + 1000;

      repeat (4) @(posedge clk);
      rst <= 1'b0;

      // Register file comes out of reset cleared
      for (int a = 0; a <= 4; a++) begin
         verify_reg(3'(a), 64'd0, "register after reset");
      end
      check_eq("ce_done after reset", 64'(ce_done), 64'd0);

      for (int j = 0; j < num_jobs; j++) begin
         run_job(j);
      end

      $display("ALL CHECKS PASSED");
      $finish;
   end

endmodule

// ==== hdl/ce_cfg_if.sv ====
interface ce_cfg_if;

   // Transfer setup from the register block
   logic [ce_pkg::CE_ADDR_W-1:0] host_addr;
   logic [ce_pkg::CE_ADDR_W-1:0] hps_addr;
   logic [ce_pkg::CE_SIZE_W-1:0] size_words;
   logic                         start;
   logic                         core_rst;
   logic                         abort;

   // Status pulses back from the engines
   logic                         rd_err;
   logic                         wr_err;
   logic                         wr_done;

   modport csr (
      output host_addr, hps_addr, size_words, start, core_rst, abort,
      input  rd_err, wr_err, wr_done
   );

   modport rd (
      input  host_addr, size_words, start, core_rst, abort,
      output rd_err
   );

   modport wr (
      input  hps_addr, size_words, start, core_rst, abort,
      output wr_err, wr_done
   );

endinterface

// ==== hdl/ce_cpl_fifo.sv ====
module ce_cpl_fifo (
   input  logic  clk,
   ce_cpl_if.fifo cpl,
   input  logic  core_rst
);

   logic [ce_pkg::CE_DATA_W-1:0]          mem [ce_pkg::CE_FIFO_DEPTH];
   logic [ce_pkg::CE_FIFO_DEPTH_LOG2-1:0] wr_ptr;
   logic [ce_pkg::CE_FIFO_DEPTH_LOG2-1:0] rd_ptr;
   logic [ce_pkg::CE_FIFO_CNT_W-1:0]      count_q;
   logic                                  full;

   assign full = (count_q == ce_pkg::CE_FIFO_CNT_W'(ce_pkg::CE_FIFO_DEPTH));

   // Storage
   always_ff @(posedge clk) begin
      if (cpl.push) begin
         mem[wr_ptr] <= cpl.push_data;
      end
   end

   // Pointers and occupancy
   always_ff @(posedge clk) begin
      if (core_rst) begin
         wr_ptr  <= '0;
         rd_ptr  <= '0;
         count_q <= '0;
      end else begin
         if (cpl.push) begin
            wr_ptr <= wr_ptr + 1'b1;
         end
         if (cpl.pop) begin
            rd_ptr <= rd_ptr + 1'b1;
         end
         case ({cpl.push, cpl.pop})
            2'b10:   count_q <= count_q + 1'b1;
            2'b01:   count_q <= count_q - 1'b1;
            default: ;
         endcase
      end
   end

   assign cpl.head_data = mem[rd_ptr];
   assign cpl.empty     = (count_q == '0);
   assign cpl.count     = count_q;

   // Credits upstream should make overflow impossible
   a_no_overflow: assert property (@(posedge clk) disable iff (core_rst)
      !(cpl.push && full));

   a_no_underflow: assert property (@(posedge clk) disable iff (core_rst)
      !(cpl.pop && cpl.empty));

endmodule

// ==== hdl/ce_cpl_if.sv ====
interface ce_cpl_if;

   // Write side
   logic                             push;
   logic [ce_pkg::CE_DATA_W-1:0]     push_data;

   // Read side, head is valid while not empty
   logic                             pop;
   logic [ce_pkg::CE_DATA_W-1:0]     head_data;
   logic                             empty;

   // Occupancy, used for credit tracking
   logic [ce_pkg::CE_FIFO_CNT_W-1:0] count;

   modport fifo (
      input  push, push_data, pop,
      output head_data, empty, count
   );

   modport producer (
      output push, push_data,
      input  count
   );

   modport consumer (
      output pop,
      input  head_data, empty
   );

endinterface

// ==== hdl/ce_csr.sv ====
module ce_csr (
   input  logic                             clk,
   input  logic                             rst,
   input  logic                             csr_wen,
   input  logic                             csr_ren,
   input  logic [ce_pkg::CE_CSR_ADDR_W-1:0] csr_addr,
   input  logic [ce_pkg::CE_DATA_W-1:0]     csr_wdata,
   output logic [ce_pkg::CE_DATA_W-1:0]     csr_rdata,
   output logic                             csr_rvalid,
   output logic                             ce_done,
   ce_cfg_if.csr                            cfg
);

   logic [ce_pkg::CE_ADDR_W-1:0] host_addr_q;
   logic [ce_pkg::CE_ADDR_W-1:0] hps_addr_q;
   logic [ce_pkg::CE_SIZE_W-1:0] size_q;
   logic                         ctrl_wr;
   logic                         start_q;
   logic                         soft_q;
   logic                         busy_q;
   logic                         done_q;
   logic                         err_q;

   assign ctrl_wr = csr_wen && (csr_addr == ce_pkg::CE_REG_CTRL);

   // ------------------------------
   // Setup registers
   // ------------------------------
   // Kept across a soft reset so software need not reprogram them
   always_ff @(posedge clk) begin
      if (rst) begin
         host_addr_q <= '0;
         hps_addr_q  <= '0;
         size_q      <= '0;
      end else if (csr_wen) begin
         case (csr_addr)
            ce_pkg::CE_REG_HOST_ADDR: host_addr_q <= csr_wdata[ce_pkg::CE_ADDR_W-1:0];
            ce_pkg::CE_REG_HPS_ADDR:  hps_addr_q  <= csr_wdata[ce_pkg::CE_ADDR_W-1:0];
            ce_pkg::CE_REG_SIZE:      size_q      <= csr_wdata[ce_pkg::CE_SIZE_W-1:0];
            default: ;
         endcase
      end
   end

   // ------------------------------
   // Control pulses
   // ------------------------------
   // Start is dropped while busy, after an error, or alongside soft reset
   always_ff @(posedge clk) begin
      if (rst) begin
         start_q <= 1'b0;
         soft_q  <= 1'b0;
      end else begin
         start_q <= ctrl_wr && csr_wdata[ce_pkg::CE_CTRL_START_BIT] &&
                    !csr_wdata[ce_pkg::CE_CTRL_SOFTRST_BIT] && !busy_q && !err_q;
         soft_q  <= ctrl_wr && csr_wdata[ce_pkg::CE_CTRL_SOFTRST_BIT];
      end
   end

   // Status, cleared by the core reset
   always_ff @(posedge clk) begin
      if (cfg.core_rst) begin
         busy_q <= 1'b0;
         done_q <= 1'b0;
         err_q  <= 1'b0;
      end else begin
         if (start_q) begin
            busy_q <= 1'b1;
            done_q <= 1'b0;
         end else if (cfg.wr_done) begin
            busy_q <= 1'b0;
            done_q <= 1'b1;
         end
         // Error wins over a late done
         if (cfg.rd_err || cfg.wr_err) begin
            err_q  <= 1'b1;
            busy_q <= 1'b0;
            done_q <= 1'b0;
         end
      end
   end

   // Read data, one cycle after csr_ren
   always_ff @(posedge clk) begin
      csr_rdata <= '0;
      if (csr_ren) begin
         case (csr_addr)
            ce_pkg::CE_REG_HOST_ADDR: csr_rdata[ce_pkg::CE_ADDR_W-1:0] <= host_addr_q;
            ce_pkg::CE_REG_HPS_ADDR:  csr_rdata[ce_pkg::CE_ADDR_W-1:0] <= hps_addr_q;
            ce_pkg::CE_REG_SIZE:      csr_rdata[ce_pkg::CE_SIZE_W-1:0] <= size_q;
            ce_pkg::CE_REG_STATUS: begin
               csr_rdata[ce_pkg::CE_STAT_BUSY_BIT] <= busy_q;
               csr_rdata[ce_pkg::CE_STAT_DONE_BIT] <= done_q;
               csr_rdata[ce_pkg::CE_STAT_ERR_BIT]  <= err_q;
            end
            default: ;
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         csr_rvalid <= 1'b0;
      end else begin
         csr_rvalid <= csr_ren;
      end
   end

   assign cfg.host_addr  = host_addr_q;
   assign cfg.hps_addr   = hps_addr_q;
   assign cfg.size_words = size_q;
   assign cfg.start      = start_q;
   assign cfg.core_rst   = rst | soft_q;
   assign cfg.abort      = err_q;
   assign ce_done        = done_q;

   // A new job never launches into a core reset
   a_start_no_rst: assert property (@(posedge clk) disable iff (rst)
      !(cfg.start && cfg.core_rst));

endmodule

// ==== hdl/ce_hps_wr.sv ====
module ce_hps_wr (
   input  logic                         clk,
   ce_cfg_if.wr                         cfg,
   ce_cpl_if.consumer                   cpl,
   output logic                         hps_wr_valid,
   output logic [ce_pkg::CE_ADDR_W-1:0] hps_wr_addr,
   output logic [ce_pkg::CE_DATA_W-1:0] hps_wr_data,
   input  logic                         hps_wr_ready,
   input  logic                         hps_bvalid,
   input  logic                         hps_berr
);

   logic                         active;
   logic                         load;
   logic [ce_pkg::CE_ADDR_W-1:0] next_addr;
   logic [ce_pkg::CE_SIZE_W-1:0] wr_cnt;
   logic [ce_pkg::CE_SIZE_W-1:0] resp_cnt;

   // ------------------------------
   // Write issue
   // ------------------------------
   // Pop the head when the output slot is free or draining this cycle
   assign load = active && !cfg.abort && !cpl.empty &&
                 (wr_cnt < cfg.size_words) &&
                 (!hps_wr_valid || hps_wr_ready);

   assign cpl.pop = load;

   always_ff @(posedge clk) begin
      if (cfg.core_rst) begin
         active       <= 1'b0;
         hps_wr_valid <= 1'b0;
         wr_cnt       <= '0;
         resp_cnt     <= '0;
      end else begin
         if (cfg.start) begin
            active   <= 1'b1;
            wr_cnt   <= '0;
            resp_cnt <= '0;
         end else if (cfg.wr_done || cfg.wr_err) begin
            active <= 1'b0;
         end
         if (load) begin
            hps_wr_valid <= 1'b1;
            wr_cnt       <= wr_cnt + 1'b1;
         end else if (hps_wr_ready) begin
            hps_wr_valid <= 1'b0;
         end
         if (hps_bvalid) begin
            resp_cnt <= resp_cnt + 1'b1;
         end
      end
   end

   // Word address walk and output beat
   always_ff @(posedge clk) begin
      if (cfg.start) begin
         next_addr <= cfg.hps_addr;
      end else if (load) begin
         next_addr <= next_addr + ce_pkg::CE_ADDR_W'(ce_pkg::CE_BEAT_BYTES);
      end
      if (load) begin
         hps_wr_addr <= next_addr;
         hps_wr_data <= cpl.head_data;
      end
   end

   // ------------------------------
   // Responses
   // ------------------------------
   // Done on the final good response, so status follows one cycle later
   assign cfg.wr_done = active && hps_bvalid && !hps_berr &&
                        (resp_cnt == cfg.size_words - 1'b1);
   assign cfg.wr_err  = active && hps_bvalid && hps_berr;

endmodule

// ==== hdl/ce_pkg.sv ====
package ce_pkg;

   // ------------------------------
   // Data path widths
   // ------------------------------
   localparam int CE_ADDR_W     = 32;
   localparam int CE_DATA_W     = 64;
   localparam int CE_BEAT_BYTES = CE_DATA_W / 8;
   localparam int CE_SIZE_W     = 16;

   // Fixed read chunk, four beats per request
   localparam int CE_CHUNK_BEATS = 4;
   localparam int CE_CHUNK_BYTES = CE_CHUNK_BEATS * CE_BEAT_BYTES;

   // Completion FIFO
   localparam int CE_FIFO_DEPTH_LOG2 = 4;
   localparam int CE_FIFO_DEPTH      = 1 << CE_FIFO_DEPTH_LOG2;
   localparam int CE_FIFO_CNT_W      = CE_FIFO_DEPTH_LOG2 + 1;

   // ------------------------------
   // Register map
   // ------------------------------
   localparam int CE_CSR_ADDR_W = 3;

   localparam logic [CE_CSR_ADDR_W-1:0] CE_REG_HOST_ADDR = 3'd0;
   localparam logic [CE_CSR_ADDR_W-1:0] CE_REG_HPS_ADDR  = 3'd1;
   localparam logic [CE_CSR_ADDR_W-1:0] CE_REG_SIZE      = 3'd2;
   localparam logic [CE_CSR_ADDR_W-1:0] CE_REG_CTRL      = 3'd3;
   localparam logic [CE_CSR_ADDR_W-1:0] CE_REG_STATUS    = 3'd4;

   // Control bits, both self clearing
   localparam int CE_CTRL_START_BIT   = 0;
   localparam int CE_CTRL_SOFTRST_BIT = 1;

   // Status bits
   localparam int CE_STAT_BUSY_BIT = 0;
   localparam int CE_STAT_DONE_BIT = 1;
   localparam int CE_STAT_ERR_BIT  = 2;

endpackage

// ==== hdl/ce_rd_req.sv ====
module ce_rd_req (
   input  logic                         clk,
   ce_cfg_if.rd                         cfg,
   ce_cpl_if.producer                   cpl,
   output logic                         rd_req_valid,
   output logic [ce_pkg::CE_ADDR_W-1:0] rd_req_addr,
   input  logic                         rd_req_ready,
   input  logic                         cpl_valid,
   input  logic [ce_pkg::CE_DATA_W-1:0] cpl_data,
   input  logic                         cpl_err
);

   logic                             active;
   logic [ce_pkg::CE_SIZE_W-1:0]     req_cnt;
   logic [ce_pkg::CE_SIZE_W-1:0]     rcv_cnt;
   logic [ce_pkg::CE_FIFO_CNT_W-1:0] pending;
   logic [ce_pkg::CE_FIFO_CNT_W-1:0] pending_n;
   logic                             credit_ok;
   logic                             issue;
   logic                             req_hs;
   logic                             last_req;

   // ------------------------------
   // Credit check
   // ------------------------------
   // Room for a whole chunk after the FIFO and the beats still in flight
   assign credit_ok = (int'(cpl.count) + int'(pending) + ce_pkg::CE_CHUNK_BEATS)
                      <= ce_pkg::CE_FIFO_DEPTH;

   assign issue    = active && !cfg.abort && !rd_req_valid && credit_ok;
   assign req_hs   = rd_req_valid && rd_req_ready;
   assign last_req = (int'(req_cnt) + ce_pkg::CE_CHUNK_BEATS) >= int'(cfg.size_words);

   always_comb begin
      pending_n = pending;
      if (req_hs) begin
         pending_n = pending_n + ce_pkg::CE_FIFO_CNT_W'(ce_pkg::CE_CHUNK_BEATS);
      end
      if (cpl_valid) begin
         pending_n = pending_n - 1'b1;
      end
   end

   always_ff @(posedge clk) begin
      if (cfg.core_rst) begin
         active       <= 1'b0;
         rd_req_valid <= 1'b0;
         req_cnt      <= '0;
         rcv_cnt      <= '0;
         pending      <= '0;
      end else begin
         if (cfg.start) begin
            active  <= 1'b1;
            req_cnt <= '0;
            rcv_cnt <= '0;
         end
         if (issue) begin
            rd_req_valid <= 1'b1;
         end else if (req_hs) begin
            rd_req_valid <= 1'b0;
            req_cnt      <= req_cnt + ce_pkg::CE_SIZE_W'(ce_pkg::CE_CHUNK_BEATS);
            if (last_req) begin
               active <= 1'b0;
            end
         end
         if (cpl.push) begin
            rcv_cnt <= rcv_cnt + 1'b1;
         end
         pending <= pending_n;
      end
   end

   // Chunk address walk
   always_ff @(posedge clk) begin
      if (cfg.start) begin
         rd_req_addr <= cfg.host_addr;
      end else if (req_hs) begin
         rd_req_addr <= rd_req_addr + ce_pkg::CE_ADDR_W'(ce_pkg::CE_CHUNK_BYTES);
      end
   end

   // ------------------------------
   // Completion intake
   // ------------------------------
   // Beats past the image size in the last chunk are dropped
   assign cpl.push      = cpl_valid && !cpl_err && (rcv_cnt < cfg.size_words);
   assign cpl.push_data = cpl_data;
   assign cfg.rd_err    = cpl_valid && cpl_err;

   a_req_stable: assert property (@(posedge clk) disable iff (cfg.core_rst)
      rd_req_valid && !rd_req_ready |=> rd_req_valid && $stable(rd_req_addr));

endmodule

// ==== hdl/ce_top.sv ====
module ce_top (
   input  logic                             clk,
   input  logic                             rst,

   // Register port
   input  logic                             csr_wen,
   input  logic                             csr_ren,
   input  logic [ce_pkg::CE_CSR_ADDR_W-1:0] csr_addr,
   input  logic [ce_pkg::CE_DATA_W-1:0]     csr_wdata,
   output logic [ce_pkg::CE_DATA_W-1:0]     csr_rdata,
   output logic                             csr_rvalid,

   // Host read requests and completions
   output logic                             rd_req_valid,
   output logic [ce_pkg::CE_ADDR_W-1:0]     rd_req_addr,
   input  logic                             rd_req_ready,
   input  logic                             cpl_valid,
   input  logic [ce_pkg::CE_DATA_W-1:0]     cpl_data,
   input  logic                             cpl_err,

   // HPS writes and responses
   output logic                             hps_wr_valid,
   output logic [ce_pkg::CE_ADDR_W-1:0]     hps_wr_addr,
   output logic [ce_pkg::CE_DATA_W-1:0]     hps_wr_data,
   input  logic                             hps_wr_ready,
   input  logic                             hps_bvalid,
   input  logic                             hps_berr,

   output logic                             ce_done
);

   ce_cfg_if cfg_if ();
   ce_cpl_if cpl_if ();

   ce_csr i_csr (
      .clk        (clk),
      .rst        (rst),
      .csr_wen    (csr_wen),
      .csr_ren    (csr_ren),
      .csr_addr   (csr_addr),
      .csr_wdata  (csr_wdata),
      .csr_rdata  (csr_rdata),
      .csr_rvalid (csr_rvalid),
      .ce_done    (ce_done),
      .cfg        (cfg_if.csr)
   );

   ce_rd_req i_rd_req (
      .clk          (clk),
      .cfg          (cfg_if.rd),
      .cpl          (cpl_if.producer),
      .rd_req_valid (rd_req_valid),
      .rd_req_addr  (rd_req_addr),
      .rd_req_ready (rd_req_ready),
      .cpl_valid    (cpl_valid),
      .cpl_data     (cpl_data),
      .cpl_err      (cpl_err)
   );

   // Host to HPS completion buffer
   ce_cpl_fifo i_cpl_fifo (
      .clk      (clk),
      .cpl      (cpl_if.fifo),
      .core_rst (cfg_if.core_rst)
   );

   ce_hps_wr i_hps_wr (
      .clk          (clk),
      .cfg          (cfg_if.wr),
      .cpl          (cpl_if.consumer),
      .hps_wr_valid (hps_wr_valid),
      .hps_wr_addr  (hps_wr_addr),
      .hps_wr_data  (hps_wr_data),
      .hps_wr_ready (hps_wr_ready),
      .hps_bvalid   (hps_bvalid),
      .hps_berr     (hps_berr)
   );

endmodule

// ==== src.f ====
hdl/ce_pkg.sv
hdl/ce_cfg_if.sv
hdl/ce_cpl_if.sv
hdl/ce_csr.sv
hdl/ce_rd_req.sv
hdl/ce_cpl_fifo.sv
hdl/ce_hps_wr.sv
hdl/ce_top.sv
bench/tb_ce_top.sv
